//--- Bender.yml
package:
  name: perf_mon

sources:
  - common/perf_mon_pkg.sv
  - design/counters/event_counter_bank.sv
  - design/occupancy_snapshot.sv
  - design/perf_reg_file.sv
  - design/perf_mon_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/perf_mon_tb.sv

//--- common/perf_mon_pkg.sv
// performance monitor shared types
// register map and event counts

package perf_mon_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths that carry a meaning
  //////////////////////////////////////////////////////////////////////

  // counter value and read data word
  typedef logic [31:0] perf_data_t;

  // host register address
  typedef logic [7:0] perf_addr_t;

  // queue occupancy count
  typedef logic [7:0] occ_t;

  //////////////////////////////////////////////////////////////////////
  // event counts and their order inside each bank
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_COMMIT_EVENTS = 3;
  localparam int unsigned NUM_STALLS        = 9;
  localparam int unsigned NUM_MISSES        = 5;

  // commit bank lanes
  localparam int unsigned COMMIT_STORE = 0;
  localparam int unsigned COMMIT_LOAD  = 1;
  localparam int unsigned COMMIT_TOTAL = 2;

  // stall bank, index k is read at STALL_BASE + k
  localparam int unsigned STALL_FETCH1   = 0;
  localparam int unsigned STALL_CTIQ     = 1;
  localparam int unsigned STALL_INSTBUF  = 2;
  localparam int unsigned STALL_FREELIST = 3;
  localparam int unsigned STALL_BACKEND  = 4;
  localparam int unsigned STALL_LDQ      = 5;
  localparam int unsigned STALL_STQ      = 6;
  localparam int unsigned STALL_IQ       = 7;
  localparam int unsigned STALL_ROB      = 8;

  // miss bank, index k is read at MISS_BASE + k
  localparam int unsigned MISS_INST     = 0;
  localparam int unsigned MISS_LOAD     = 1;
  localparam int unsigned MISS_STORE    = 2;
  localparam int unsigned MISS_L2_INST  = 3;
  localparam int unsigned MISS_L2_DATA  = 4;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  localparam perf_addr_t ADDR_CYCLES       = 8'h00;
  localparam perf_addr_t ADDR_COMMIT_STORE = 8'h01;
  localparam perf_addr_t ADDR_COMMIT_LOAD  = 8'h02;
  localparam perf_addr_t ADDR_COMMIT_TOTAL = 8'h05;
  localparam perf_addr_t ADDR_OCC_0        = 8'h10;
  localparam perf_addr_t ADDR_OCC_1        = 8'h11;
  localparam perf_addr_t ADDR_STATUS       = 8'h20;
  localparam perf_addr_t STALL_BASE        = 8'h40;
  localparam perf_addr_t MISS_BASE         = 8'h50;

  // returned for any address outside the map
  localparam perf_data_t READ_DEFAULT = 32'h0000_0055;

endpackage

//--- design/counters/event_counter_bank.sv
// bank of lane-count event counters
`timescale 1ns/10ps

module event_counter_bank #(
  parameter int unsigned NUM_EVENTS = 1,
  parameter int unsigned LANES      = 1
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      run_i,
  input  logic                                      global_clr_i,
  input  logic [NUM_EVENTS-1:0]                     clr_sel_i,
  input  logic [NUM_EVENTS*LANES-1:0]               events_i,
  output perf_mon_pkg::perf_data_t [NUM_EVENTS-1:0] counts_o
);

  // wide enough to hold a count of all lanes set
  localparam int unsigned SUM_W = $clog2(LANES + 1);

  logic [SUM_W-1:0] lane_sum [NUM_EVENTS];

  //////////////////////////////////////////////////////////////////////
  // set lanes per event this cycle
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int e = 0; e < NUM_EVENTS; e++)
    begin
      lane_sum[e] = '0;
      for (int l = 0; l < LANES; l++)
      begin
        lane_sum[e] = lane_sum[e] + SUM_W'(events_i[e*LANES + l]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////////////////////////

  // global clear wins over run and the per-counter clear
  always_ff @(posedge clk)
  begin
    if (reset || global_clr_i)
    begin
      counts_o <= '0;
    end
    else if (run_i)
    begin
      for (int e = 0; e < NUM_EVENTS; e++)
      begin
        if (clr_sel_i[e])
          counts_o[e] <= '0;
        else
          // wraps at 2^32
          counts_o[e] <= counts_o[e] + perf_mon_pkg::perf_data_t'(lane_sum[e]);
      end
    end
  end

endmodule

//--- design/occupancy_snapshot.sv
// queue occupancy and stall status snapshot
`timescale 1ns/10ps

module occupancy_snapshot (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                run_i,
  input  logic                                global_clr_i,

  input  perf_mon_pkg::occ_t                  ib_count_i,
  input  perf_mon_pkg::occ_t                  fl_count_i,
  input  perf_mon_pkg::occ_t                  iq_count_i,
  input  perf_mon_pkg::occ_t                  ldq_count_i,
  input  perf_mon_pkg::occ_t                  stq_count_i,
  // bit k is stall k, fetch1 at bit 0
  input  logic [perf_mon_pkg::NUM_STALLS-1:0] stall_i,

  output perf_mon_pkg::occ_t                  ib_occ_o,
  output perf_mon_pkg::occ_t                  fl_occ_o,
  output perf_mon_pkg::occ_t                  iq_occ_o,
  output perf_mon_pkg::occ_t                  ldq_occ_o,
  output perf_mon_pkg::occ_t                  stq_occ_o,
  output logic [perf_mon_pkg::NUM_STALLS-1:0] status_o
);

  localparam int unsigned NS = perf_mon_pkg::NUM_STALLS;

  logic [NS-1:0] status_next;

  // status word puts fetch1 at the top and rob at bit 0
  always_comb
  begin
    for (int k = 0; k < NS; k++)
    begin
      status_next[NS-1-k] = stall_i[k];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset || global_clr_i)
    begin
      ib_occ_o  <= '0;
      fl_occ_o  <= '0;
      iq_occ_o  <= '0;
      ldq_occ_o <= '0;
      stq_occ_o <= '0;
      status_o  <= '0;
    end
    else if (run_i)
    begin
      ib_occ_o  <= ib_count_i;
      fl_occ_o  <= fl_count_i;
      iq_occ_o  <= iq_count_i;
      ldq_occ_o <= ldq_count_i;
      stq_occ_o <= stq_count_i;
      status_o  <= status_next;
    end
  end

endmodule

//--- design/perf_mon_top.sv
// performance monitor top level
`timescale 1ns/10ps

module perf_mon_top #(
  parameter int unsigned COMMIT_WIDTH = 4
) (
  input  logic                     clk,
  input  logic                     reset,

  // host register port
  input  perf_mon_pkg::perf_addr_t perf_addr_i,
  output perf_mon_pkg::perf_data_t perf_data_o,
  input  logic                     run_i,
  input  logic                     clr_i,
  input  logic                     global_clr_i,

  // commit lanes
  input  logic [COMMIT_WIDTH-1:0]  commit_store_i,
  input  logic [COMMIT_WIDTH-1:0]  commit_load_i,
  input  logic [COMMIT_WIDTH-1:0]  commit_valid_i,

  // pipeline stalls
  input  logic                     fetch1_stall_i,
  input  logic                     ctiq_stall_i,
  input  logic                     instbuf_stall_i,
  input  logic                     freelist_stall_i,
  input  logic                     backend_stall_i,
  input  logic                     ldq_stall_i,
  input  logic                     stq_stall_i,
  input  logic                     iq_stall_i,
  input  logic                     rob_stall_i,

  // memory misses and L2 requests
  input  logic                     inst_miss_i,
  input  logic                     load_miss_i,
  input  logic                     store_miss_i,
  input  logic                     l2_inst_req_i,
  input  logic                     l2_data_req_i,

  // queue occupancies
  input  perf_mon_pkg::occ_t       ib_count_i,
  input  perf_mon_pkg::occ_t       fl_count_i,
  input  perf_mon_pkg::occ_t       iq_count_i,
  input  perf_mon_pkg::occ_t       ldq_count_i,
  input  perf_mon_pkg::occ_t       stq_count_i
);

  localparam int unsigned NC = perf_mon_pkg::NUM_COMMIT_EVENTS;
  localparam int unsigned NS = perf_mon_pkg::NUM_STALLS;
  localparam int unsigned NM = perf_mon_pkg::NUM_MISSES;

  logic [NC*COMMIT_WIDTH-1:0] commit_events;
  logic [NS-1:0]              stall_vec;
  logic [NM-1:0]              miss_vec;

  logic [NC-1:0] commit_clr_sel;
  logic [NS-1:0] stall_clr_sel;
  logic [NM-1:0] miss_clr_sel;

  perf_mon_pkg::perf_data_t [NC-1:0] commit_counts;
  perf_mon_pkg::perf_data_t [NS-1:0] stall_counts;
  perf_mon_pkg::perf_data_t [NM-1:0] miss_counts;

  perf_mon_pkg::occ_t ib_occ;
  perf_mon_pkg::occ_t fl_occ;
  perf_mon_pkg::occ_t iq_occ;
  perf_mon_pkg::occ_t ldq_occ;
  perf_mon_pkg::occ_t stq_occ;
  logic [NS-1:0]      status;

  //////////////////////////////////////////////////////////////////////
  // pack loose event bits in bank order
  //////////////////////////////////////////////////////////////////////

  assign commit_events[perf_mon_pkg::COMMIT_STORE*COMMIT_WIDTH +: COMMIT_WIDTH] = commit_store_i;
  assign commit_events[perf_mon_pkg::COMMIT_LOAD*COMMIT_WIDTH +: COMMIT_WIDTH]  = commit_load_i;
  assign commit_events[perf_mon_pkg::COMMIT_TOTAL*COMMIT_WIDTH +: COMMIT_WIDTH] = commit_valid_i;

  assign stall_vec[perf_mon_pkg::STALL_FETCH1]   = fetch1_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_CTIQ]     = ctiq_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_INSTBUF]  = instbuf_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_FREELIST] = freelist_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_BACKEND]  = backend_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_LDQ]      = ldq_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_STQ]      = stq_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_IQ]       = iq_stall_i;
  assign stall_vec[perf_mon_pkg::STALL_ROB]      = rob_stall_i;

  assign miss_vec[perf_mon_pkg::MISS_INST]    = inst_miss_i;
  assign miss_vec[perf_mon_pkg::MISS_LOAD]    = load_miss_i;
  assign miss_vec[perf_mon_pkg::MISS_STORE]   = store_miss_i;
  assign miss_vec[perf_mon_pkg::MISS_L2_INST] = l2_inst_req_i;
  assign miss_vec[perf_mon_pkg::MISS_L2_DATA] = l2_data_req_i;

  //////////////////////////////////////////////////////////////////////
  // counter banks
  //////////////////////////////////////////////////////////////////////

  // commit counters add the number of set lanes per cycle
  event_counter_bank #(
    .NUM_EVENTS (NC),
    .LANES      (COMMIT_WIDTH)
  ) commit_bank (
    .clk          (clk),
    .reset        (reset),
    .run_i        (run_i),
    .global_clr_i (global_clr_i),
    .clr_sel_i    (commit_clr_sel),
    .events_i     (commit_events),
    .counts_o     (commit_counts)
  );

  event_counter_bank #(
    .NUM_EVENTS (NS),
    .LANES      (1)
  ) stall_bank (
    .clk          (clk),
    .reset        (reset),
    .run_i        (run_i),
    .global_clr_i (global_clr_i),
    .clr_sel_i    (stall_clr_sel),
    .events_i     (stall_vec),
    .counts_o     (stall_counts)
  );

  event_counter_bank #(
    .NUM_EVENTS (NM),
    .LANES      (1)
  ) miss_bank (
    .clk          (clk),
    .reset        (reset),
    .run_i        (run_i),
    .global_clr_i (global_clr_i),
    .clr_sel_i    (miss_clr_sel),
    .events_i     (miss_vec),
    .counts_o     (miss_counts)
  );

  occupancy_snapshot u_snapshot (
    .clk          (clk),
    .reset        (reset),
    .run_i        (run_i),
    .global_clr_i (global_clr_i),
    .ib_count_i   (ib_count_i),
    .fl_count_i   (fl_count_i),
    .iq_count_i   (iq_count_i),
    .ldq_count_i  (ldq_count_i),
    .stq_count_i  (stq_count_i),
    .stall_i      (stall_vec),
    .ib_occ_o     (ib_occ),
    .fl_occ_o     (fl_occ),
    .iq_occ_o     (iq_occ),
    .ldq_occ_o    (ldq_occ),
    .stq_occ_o    (stq_occ),
    .status_o     (status)
  );

  perf_reg_file u_reg_file (
    .clk              (clk),
    .reset            (reset),
    .run_i            (run_i),
    .clr_i            (clr_i),
    .global_clr_i     (global_clr_i),
    .addr_i           (perf_addr_i),
    .commit_counts_i  (commit_counts),
    .stall_counts_i   (stall_counts),
    .miss_counts_i    (miss_counts),
    .ib_occ_i         (ib_occ),
    .fl_occ_i         (fl_occ),
    .iq_occ_i         (iq_occ),
    .ldq_occ_i        (ldq_occ),
    .stq_occ_i        (stq_occ),
    .status_i         (status),
    .commit_clr_sel_o (commit_clr_sel),
    .stall_clr_sel_o  (stall_clr_sel),
    .miss_clr_sel_o   (miss_clr_sel),
    .data_o           (perf_data_o)
  );

endmodule

//--- design/perf_reg_file.sv
// host register file and cycle counter
`timescale 1ns/10ps

module perf_reg_file (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     run_i,
  input  logic                     clr_i,
  input  logic                     global_clr_i,
  input  perf_mon_pkg::perf_addr_t addr_i,

  input  perf_mon_pkg::perf_data_t [perf_mon_pkg::NUM_COMMIT_EVENTS-1:0] commit_counts_i,
  input  perf_mon_pkg::perf_data_t [perf_mon_pkg::NUM_STALLS-1:0]        stall_counts_i,
  input  perf_mon_pkg::perf_data_t [perf_mon_pkg::NUM_MISSES-1:0]        miss_counts_i,

  input  perf_mon_pkg::occ_t       ib_occ_i,
  input  perf_mon_pkg::occ_t       fl_occ_i,
  input  perf_mon_pkg::occ_t       iq_occ_i,
  input  perf_mon_pkg::occ_t       ldq_occ_i,
  input  perf_mon_pkg::occ_t       stq_occ_i,
  input  logic [perf_mon_pkg::NUM_STALLS-1:0] status_i,

  output logic [perf_mon_pkg::NUM_COMMIT_EVENTS-1:0] commit_clr_sel_o,
  output logic [perf_mon_pkg::NUM_STALLS-1:0]        stall_clr_sel_o,
  output logic [perf_mon_pkg::NUM_MISSES-1:0]        miss_clr_sel_o,
  output perf_mon_pkg::perf_data_t                   data_o
);

  // commit counters do not sit at consecutive addresses
  localparam perf_mon_pkg::perf_addr_t COMMIT_ADDR [perf_mon_pkg::NUM_COMMIT_EVENTS] = '{
    perf_mon_pkg::ADDR_COMMIT_STORE,
    perf_mon_pkg::ADDR_COMMIT_LOAD,
    perf_mon_pkg::ADDR_COMMIT_TOTAL
  };

  logic                     clr_hit;
  logic                     cycle_clr_sel;
  perf_mon_pkg::perf_data_t cycle_q;
  perf_mon_pkg::perf_data_t rd_next;

  //////////////////////////////////////////////////////////////////////
  // clear select decode
  //////////////////////////////////////////////////////////////////////

  // a clear only acts in a run cycle
  assign clr_hit       = clr_i && run_i;
  assign cycle_clr_sel = clr_hit && (addr_i == perf_mon_pkg::ADDR_CYCLES);

  always_comb
  begin
    for (int k = 0; k < perf_mon_pkg::NUM_COMMIT_EVENTS; k++)
    begin
      commit_clr_sel_o[k] = clr_hit && (addr_i == COMMIT_ADDR[k]);
    end
    for (int k = 0; k < perf_mon_pkg::NUM_STALLS; k++)
    begin
      stall_clr_sel_o[k] = clr_hit &&
                           (addr_i == perf_mon_pkg::STALL_BASE + perf_mon_pkg::perf_addr_t'(k));
    end
    for (int k = 0; k < perf_mon_pkg::NUM_MISSES; k++)
    begin
      miss_clr_sel_o[k] = clr_hit &&
                          (addr_i == perf_mon_pkg::MISS_BASE + perf_mon_pkg::perf_addr_t'(k));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // run cycle counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset || global_clr_i)
    begin
      cycle_q <= '0;
    end
    else if (run_i)
    begin
      if (cycle_clr_sel)
        cycle_q <= '0;
      else
        cycle_q <= cycle_q + perf_mon_pkg::perf_data_t'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux, one cycle of latency
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (addr_i)
      perf_mon_pkg::ADDR_CYCLES: rd_next = cycle_q;
      perf_mon_pkg::ADDR_OCC_0:  rd_next = {ib_occ_i, fl_occ_i, iq_occ_i, ldq_occ_i};
      perf_mon_pkg::ADDR_OCC_1:  rd_next = perf_mon_pkg::perf_data_t'(stq_occ_i);
      perf_mon_pkg::ADDR_STATUS: rd_next = perf_mon_pkg::perf_data_t'(status_i);
      default:                   rd_next = perf_mon_pkg::READ_DEFAULT;
    endcase

    // counter banks override the default
    for (int k = 0; k < perf_mon_pkg::NUM_COMMIT_EVENTS; k++)
    begin
      if (addr_i == COMMIT_ADDR[k])
        rd_next = commit_counts_i[k];
    end
    for (int k = 0; k < perf_mon_pkg::NUM_STALLS; k++)
    begin
      if (addr_i == perf_mon_pkg::STALL_BASE + perf_mon_pkg::perf_addr_t'(k))
        rd_next = stall_counts_i[k];
    end
    for (int k = 0; k < perf_mon_pkg::NUM_MISSES; k++)
    begin
      if (addr_i == perf_mon_pkg::MISS_BASE + perf_mon_pkg::perf_addr_t'(k))
        rd_next = miss_counts_i[k];
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      data_o <= '0;
    else
      data_o <= rd_next;
  end

endmodule

//--- tests/perf_mon_tasks.svh
// directed tests and check helpers

function automatic logic [31:0] count_set_bits(input logic [COMMIT_WIDTH-1:0] v);
  logic [31:0] n;
  n = '0;
  for (int i = 0; i < COMMIT_WIDTH; i++)
    n = n + 32'(v[i]);
  return n;
endfunction

task automatic set_idle_inputs();
  perf_addr_i    = '0;
  run_i          = 1'b0;
  clr_i          = 1'b0;
  global_clr_i   = 1'b0;
  commit_store_i = '0;
  commit_load_i  = '0;
  commit_valid_i = '0;
  stall          = '0;
  miss           = '0;
  ib_count_i     = '0;
  fl_count_i     = '0;
  iq_count_i     = '0;
  ldq_count_i    = '0;
  stq_count_i    = '0;
endtask

task automatic clear_model();
  exp_cycles = '0;
  for (int k = 0; k < 3; k++)
    exp_commit[k] = '0;
  for (int k = 0; k < 9; k++)
    exp_stall[k] = '0;
  for (int k = 0; k < 5; k++)
    exp_miss[k] = '0;
  exp_occ0   = '0;
  exp_occ1   = '0;
  exp_status = '0;
endtask

// apply one clock edge to the model, then to the DUT
task automatic advance_cycle();
  logic sel;
  sel = 1'b0;
  if (global_clr_i)
  begin
    clear_model();
  end
  else if (run_i)
  begin
    sel        = clr_i && (perf_addr_i == 8'h00);
    exp_cycles = sel ? '0 : exp_cycles + 1;
    sel           = clr_i && (perf_addr_i == 8'h01);
    exp_commit[0] = sel ? '0 : exp_commit[0] + count_set_bits(commit_store_i);
    sel           = clr_i && (perf_addr_i == 8'h02);
    exp_commit[1] = sel ? '0 : exp_commit[1] + count_set_bits(commit_load_i);
    sel           = clr_i && (perf_addr_i == 8'h05);
    exp_commit[2] = sel ? '0 : exp_commit[2] + count_set_bits(commit_valid_i);
    for (int k = 0; k < 9; k++)
    begin
      sel          = clr_i && (perf_addr_i == 8'(8'h40 + k));
      exp_stall[k] = sel ? '0 : exp_stall[k] + 32'(stall[k]);
      // fetch1 lands in the top status bit
      exp_status[8-k] = stall[k];
    end
    for (int k = 0; k < 5; k++)
    begin
      sel         = clr_i && (perf_addr_i == 8'(8'h50 + k));
      exp_miss[k] = sel ? '0 : exp_miss[k] + 32'(miss[k]);
    end
    exp_occ0 = {ib_count_i, fl_count_i, iq_count_i, ldq_count_i};
    exp_occ1 = {24'h0, stq_count_i};
  end
  @(posedge clk);
  #(DRIVE_DELAY);
endtask

// data shows up one edge after the address
task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
  perf_addr_i = addr;
  @(posedge clk);
  #1;
  checks++;
  if (perf_data_o !== exp)
  begin
    errors++;
    $display("Error: time %0t, perf_data_o at addr 0x%02h expected 0x%08h, got 0x%08h",
             $time, addr, exp, perf_data_o);
  end
  #(DRIVE_DELAY - 1);
endtask

task automatic check_all_mapped();
  read_check(8'h00, exp_cycles);
  read_check(8'h01, exp_commit[0]);
  read_check(8'h02, exp_commit[1]);
  read_check(8'h05, exp_commit[2]);
  read_check(8'h10, exp_occ0);
  read_check(8'h11, exp_occ1);
  read_check(8'h20, exp_status);
  for (int k = 0; k < 9; k++)
    read_check(8'(8'h40 + k), exp_stall[k]);
  for (int k = 0; k < 5; k++)
    read_check(8'(8'h50 + k), exp_miss[k]);
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic check_reset_values();
  check_all_mapped();
  read_check(8'h7F, 32'h55);
  read_check(8'h03, 32'h55);
  read_check(8'h49, 32'h55);
endtask

task automatic count_commits();
  run_i = 1'b1;
  for (int i = 0; i < 50; i++)
  begin
    commit_store_i = COMMIT_WIDTH'($urandom);
    commit_load_i  = COMMIT_WIDTH'($urandom) & ~commit_store_i;
    // valid lanes cover every store and load lane
    commit_valid_i = COMMIT_WIDTH'($urandom) | commit_store_i | commit_load_i;
    advance_cycle();
  end
  set_idle_inputs();
  read_check(8'h00, 32'd50);
  check_all_mapped();
endtask

task automatic count_stalls_and_misses();
  run_i = 1'b1;
  for (int i = 0; i < 40; i++)
  begin
    stall = 9'($urandom);
    miss  = 5'($urandom);
    advance_cycle();
  end
  set_idle_inputs();
  check_all_mapped();
endtask

task automatic snapshot_occupancy();
  run_i = 1'b1;
  for (int i = 0; i < 3; i++)
  begin
    ib_count_i  = 8'($urandom);
    fl_count_i  = 8'($urandom);
    iq_count_i  = 8'($urandom);
    ldq_count_i = 8'($urandom);
    stq_count_i = 8'($urandom);
    advance_cycle();
  end
  // new values while stopped must not reach the snapshot
  run_i       = 1'b0;
  ib_count_i  = ~ib_count_i;
  fl_count_i  = ~fl_count_i;
  iq_count_i  = ~iq_count_i;
  ldq_count_i = ~ldq_count_i;
  stq_count_i = ~stq_count_i;
  advance_cycle();
  check_all_mapped();
endtask

task automatic clear_one_counter();
  run_i       = 1'b1;
  clr_i       = 1'b1;
  perf_addr_i = 8'h41;
  advance_cycle();
  clr_i    = 1'b0;
  stall[1] = 1'b1;
  for (int i = 0; i < 7; i++)
    advance_cycle();
  set_idle_inputs();
  read_check(8'h41, 32'd7);
  check_all_mapped();
endtask

task automatic global_clear_priority();
  run_i          = 1'b1;
  clr_i          = 1'b1;
  global_clr_i   = 1'b1;
  perf_addr_i    = 8'h40;
  commit_store_i = '1;
  commit_load_i  = '1;
  commit_valid_i = '1;
  stall          = '1;
  miss           = '1;
  ib_count_i     = 8'($urandom);
  stq_count_i    = 8'($urandom);
  advance_cycle();
  set_idle_inputs();
  check_all_mapped();
  read_check(8'h7F, 32'h55);
endtask

//--- tests/perf_mon_tb.sv
// performance monitor testbench
`timescale 1ns/10ps

module perf_mon_tb;

  localparam int COMMIT_WIDTH = 4;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_CYCLES   = 3000;
  localparam int DRIVE_DELAY  = 2;

  logic                    clk;
  logic                    reset;
  logic [7:0]              perf_addr_i;
  logic [31:0]             perf_data_o;
  logic                    run_i;
  logic                    clr_i;
  logic                    global_clr_i;
  logic [COMMIT_WIDTH-1:0] commit_store_i;
  logic [COMMIT_WIDTH-1:0] commit_load_i;
  logic [COMMIT_WIDTH-1:0] commit_valid_i;
  // bit k is stall k in fetch1 .. rob order
  logic [8:0]              stall;
  // bit k is miss k in instMiss .. l2DataReq order
  logic [4:0]              miss;
  logic [7:0]              ib_count_i;
  logic [7:0]              fl_count_i;
  logic [7:0]              iq_count_i;
  logic [7:0]              ldq_count_i;
  logic [7:0]              stq_count_i;

  // reference model of every mapped register
  logic [31:0] exp_cycles;
  logic [31:0] exp_commit [3];
  logic [31:0] exp_stall [9];
  logic [31:0] exp_miss [5];
  logic [31:0] exp_occ0;
  logic [31:0] exp_occ1;
  logic [31:0] exp_status;

  int          checks;
  int          errors;
  int unsigned seed_val;

  `include "perf_mon_tasks.svh"

  perf_mon_top #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) dut (
    .clk              (clk),
    .reset            (reset),
    .perf_addr_i      (perf_addr_i),
    .perf_data_o      (perf_data_o),
    .run_i            (run_i),
    .clr_i            (clr_i),
    .global_clr_i     (global_clr_i),
    .commit_store_i   (commit_store_i),
    .commit_load_i    (commit_load_i),
    .commit_valid_i   (commit_valid_i),
    .fetch1_stall_i   (stall[0]),
    .ctiq_stall_i     (stall[1]),
    .instbuf_stall_i  (stall[2]),
    .freelist_stall_i (stall[3]),
    .backend_stall_i  (stall[4]),
    .ldq_stall_i      (stall[5]),
    .stq_stall_i      (stall[6]),
    .iq_stall_i       (stall[7]),
    .rob_stall_i      (stall[8]),
    .inst_miss_i      (miss[0]),
    .load_miss_i      (miss[1]),
    .store_miss_i     (miss[2]),
    .l2_inst_req_i    (miss[3]),
    .l2_data_req_i    (miss[4]),
    .ib_count_i       (ib_count_i),
    .fl_count_i       (fl_count_i),
    .iq_count_i       (iq_count_i),
    .ldq_count_i      (ldq_count_i),
    .stq_count_i      (stq_count_i)
  );

  //////////////////////////////////////////////////////////////////////
  // clock and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin : watchdog
    int n;
    n = 0;
    while (n < MAX_CYCLES)
    begin
      @(posedge clk);
      n++;
    end
    $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    seed_val = $urandom(32'h695d8595);
    checks   = 0;
    errors   = 0;
    reset    = 1'b1;
    set_idle_inputs();
    clear_model();

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;

    check_reset_values();
    count_commits();
    count_stalls_and_misses();
    snapshot_occupancy();
    clear_one_counter();
    global_clear_priority();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+tests
common/perf_mon_pkg.sv
design/counters/event_counter_bank.sv
design/occupancy_snapshot.sv
design/perf_reg_file.sv
design/perf_mon_top.sv
tests/perf_mon_tb.sv
